/* hdl/anpc_bridge_top.sv */
`timescale 1ns/1ps

module anpc_bridge_top (
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  logic                                           wb_cyc,
    input  logic                                           wb_stb,
    input  logic                                           wb_we,
    input  anpc_pkg::wb_addr_t                             wb_adr,
    input  anpc_pkg::wb_data_t                             wb_dat_w,
    output anpc_pkg::wb_data_t                             wb_dat_r,
    output logic                                           wb_ack,
    output logic [anpc_pkg::NUM_LEGS*anpc_pkg::GATE_W-1:0] gates,
    output logic                                           irq
);
    import anpc_pkg::*;

    tdelay_t               t_short;
    tdelay_t               t_off_on;
    tdelay_t               t_on_off_v0;
    tdelay_t               t_off_v0_on;
    tdelay_t               t_off_on_i0;
    logic [NUM_LEGS-1:0]   req;
    leg_state_t            target;
    logic [2*NUM_LEGS-1:0] flag_clear;
    logic [NUM_LEGS-1:0]   leg_busy;
    logic [NUM_LEGS-1:0]   leg_done;
    logic [NUM_LEGS-1:0]   leg_reject;
    leg_state_t            leg_state [NUM_LEGS];
    gate_word_t            leg_gate [NUM_LEGS];
    logic [NUM_LEGS-1:0]   done_flags;
    logic [NUM_LEGS-1:0]   reject_flags;

    wb_leg_regs u_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .leg_busy     (leg_busy),
        .leg_state    (leg_state),
        .done_flags   (done_flags),
        .reject_flags (reject_flags),
        .irq          (irq),
        .t_short      (t_short),
        .t_off_on     (t_off_on),
        .t_on_off_v0  (t_on_off_v0),
        .t_off_v0_on  (t_off_v0_on),
        .t_off_on_i0  (t_off_on_i0),
        .req          (req),
        .target       (target),
        .flag_clear   (flag_clear)
    );

    ////////////////////
    // Converter legs
    ////////////////////
    for (genvar g = 0; g < NUM_LEGS; g++) begin : g_leg
        leg_sequencer u_leg (
            .clk         (clk),
            .rst_n       (rst_n),
            .t_short     (t_short),
            .t_off_on    (t_off_on),
            .t_on_off_v0 (t_on_off_v0),
            .t_off_v0_on (t_off_v0_on),
            .t_off_on_i0 (t_off_on_i0),
            .req         (req[g]),
            .target      (target),
            .gate_word   (leg_gate[g]),
            .busy        (leg_busy[g]),
            .done        (leg_done[g]),
            .reject      (leg_reject[g]),
            .state       (leg_state[g])
        );
    end

    gate_output_stage u_out (
        .clk          (clk),
        .rst_n        (rst_n),
        .leg_gate     (leg_gate),
        .leg_done     (leg_done),
        .leg_reject   (leg_reject),
        .flag_clear   (flag_clear),
        .gates        (gates),
        .done_flags   (done_flags),
        .reject_flags (reject_flags),
        .irq          (irq)
    );

endmodule

/* hdl/anpc_pkg.sv */
package anpc_pkg;

    localparam int NUM_LEGS = 3;
    localparam int TDELAY_W = 16;
    localparam int GATE_W   = 6;

    typedef logic [TDELAY_W-1:0] tdelay_t;
    typedef logic [GATE_W-1:0]   gate_word_t;  // S5 down to S0
    typedef logic [1:0]          step_t;
    typedef logic [2:0]          dt_sel_t;
    typedef logic [3:0]          wb_addr_t;
    typedef logic [31:0]         wb_data_t;

    typedef enum logic [2:0] {
        P    = 3'd0,
        Z_U2 = 3'd1,
        Z_U1 = 3'd2,
        Z_L1 = 3'd3,
        Z_L2 = 3'd4,
        N    = 3'd5
    } leg_state_t;

    ////////////////////
    // Steady gate words per switching state
    ////////////////////
    localparam gate_word_t GATE_P    = 6'b110_001;
    localparam gate_word_t GATE_Z_U2 = 6'b010_010;
    localparam gate_word_t GATE_Z_U1 = 6'b010_110;
    localparam gate_word_t GATE_Z_L1 = 6'b101_001;
    localparam gate_word_t GATE_Z_L2 = 6'b001_001;
    localparam gate_word_t GATE_N    = 6'b001_110;

    localparam dt_sel_t DT_SHORT     = 3'd0;
    localparam dt_sel_t DT_OFF_ON    = 3'd1;
    localparam dt_sel_t DT_ON_OFF_V0 = 3'd2;
    localparam dt_sel_t DT_OFF_V0_ON = 3'd3;
    localparam dt_sel_t DT_OFF_ON_I0 = 3'd4;

    localparam tdelay_t DEF_T_SHORT     = 16'd4;
    localparam tdelay_t DEF_T_OFF_ON    = 16'd10;
    localparam tdelay_t DEF_T_ON_OFF_V0 = 16'd6;
    localparam tdelay_t DEF_T_OFF_V0_ON = 16'd8;
    localparam tdelay_t DEF_T_OFF_ON_I0 = 16'd12;

    ////////////////////
    // Register map, word addresses
    ////////////////////
    localparam wb_addr_t ADDR_T_SHORT     = 4'd0;
    localparam wb_addr_t ADDR_T_OFF_ON    = 4'd1;
    localparam wb_addr_t ADDR_T_ON_OFF_V0 = 4'd2;
    localparam wb_addr_t ADDR_T_OFF_V0_ON = 4'd3;
    localparam wb_addr_t ADDR_T_OFF_ON_I0 = 4'd4;
    localparam wb_addr_t ADDR_CMD0        = 4'd8;  // Legs at 8, 9, 10
    localparam wb_addr_t ADDR_STATUS      = 4'd12;

    function automatic gate_word_t steady_word(leg_state_t s);
        case (s)
            P:       return GATE_P;
            Z_U2:    return GATE_Z_U2;
            Z_U1:    return GATE_Z_U1;
            Z_L1:    return GATE_Z_L1;
            Z_L2:    return GATE_Z_L2;
            default: return GATE_N;
        endcase
    endfunction

endpackage

/* hdl/commutation_table.sv */
`timescale 1ns/1ps

module commutation_table (
    input  anpc_pkg::leg_state_t state,
    input  anpc_pkg::leg_state_t old_state,
    input  anpc_pkg::step_t      step,
    output anpc_pkg::gate_word_t gate_word,
    output anpc_pkg::dt_sel_t    dt_sel,
    output logic                 last_step,
    output logic                 legal
);
    import anpc_pkg::*;

    gate_word_t       fin;     // Steady word of the new state
    gate_word_t [3:0] words;   // Step 0 in the low slot
    dt_sel_t    [3:0] dts;
    step_t            n_last;  // Index of the final step

    assign fin = steady_word(state);

    always_comb begin
        words  = {4{fin}};
        dts    = {4{DT_SHORT}};
        n_last = '0;
        case (state)
            P: begin
                case (old_state)
                    Z_U2: begin
                        words  = {fin, fin, 6'b110_000, 6'b010_000};
                        dts    = {DT_SHORT, DT_SHORT, DT_SHORT, DT_OFF_ON};
                        n_last = 2'd2;
                    end
                    Z_U1: begin
                        words  = {fin, 6'b010_001, 6'b010_011, 6'b010_010};
                        dts    = {DT_SHORT, DT_OFF_ON, DT_SHORT, DT_OFF_ON_I0};
                        n_last = 2'd3;
                    end
                    Z_L1: begin
                        words  = {fin, fin, fin, 6'b100_001};
                        dts    = {DT_SHORT, DT_SHORT, DT_SHORT, DT_OFF_ON};
                        n_last = 2'd1;
                    end
                    Z_L2: begin
                        words  = {fin, fin, 6'b010_001, 6'b011_001};
                        dts    = {DT_SHORT, DT_SHORT, DT_OFF_ON, DT_SHORT};
                        n_last = 2'd2;
                    end
                    default: ;
                endcase
            end
            Z_U2: begin
                case (old_state)
                    P: begin
                        words  = {fin, fin, 6'b010_000, 6'b110_000};
                        dts    = {DT_SHORT, DT_SHORT, DT_OFF_ON, DT_SHORT};
                        n_last = 2'd2;
                    end
                    N: begin
                        words  = {fin, fin, 6'b011_010, 6'b001_010};
                        dts    = {DT_SHORT, DT_ON_OFF_V0, DT_ON_OFF_V0, DT_OFF_ON};
                        n_last = 2'd2;
                    end
                    default: ;
                endcase
            end
            Z_U1: begin
                if (old_state == N) begin
                    words  = {fin, fin, fin, 6'b000_110};
                    dts    = {DT_SHORT, DT_SHORT, DT_SHORT, DT_OFF_ON};
                    n_last = 2'd1;
                end
            end
            Z_L1: begin
                if (old_state == P) begin
                    words  = {fin, fin, fin, 6'b100_001};
                    dts    = {DT_SHORT, DT_SHORT, DT_SHORT, DT_OFF_ON};
                    n_last = 2'd1;
                end
            end
            Z_L2: begin
                case (old_state)
                    P: begin  // Passes through the zero-voltage clamp
                        words  = {fin, fin, 6'b011_001, 6'b010_001};
                        dts    = {DT_SHORT, DT_OFF_V0_ON, DT_ON_OFF_V0, DT_OFF_ON};
                        n_last = 2'd2;
                    end
                    N: begin
                        words  = {fin, fin, 6'b001_000, 6'b001_100};
                        dts    = {DT_SHORT, DT_SHORT, DT_OFF_ON, DT_SHORT};
                        n_last = 2'd2;
                    end
                    default: ;
                endcase
            end
            N: begin
                case (old_state)
                    Z_U2: begin
                        words  = {fin, fin, 6'b001_010, 6'b011_010};
                        dts    = {DT_SHORT, DT_SHORT, DT_OFF_ON, DT_SHORT};
                        n_last = 2'd2;
                    end
                    Z_U1: begin
                        words  = {fin, fin, fin, 6'b000_110};
                        dts    = {DT_SHORT, DT_SHORT, DT_SHORT, DT_OFF_ON};
                        n_last = 2'd1;
                    end
                    Z_L1: begin
                        words  = {fin, 6'b001_010, 6'b001_011, 6'b001_001};
                        dts    = {DT_SHORT, DT_OFF_ON, DT_SHORT, DT_OFF_ON_I0};
                        n_last = 2'd3;
                    end
                    Z_L2: begin
                        words  = {fin, fin, 6'b001_100, 6'b001_000};
                        dts    = {DT_SHORT, DT_SHORT, DT_SHORT, DT_OFF_ON};
                        n_last = 2'd2;
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

    assign gate_word = words[step];
    assign dt_sel    = dts[step];
    assign last_step = (step == n_last);
    assign legal     = (n_last != '0);  // Every defined pair has two steps or more

endmodule

/* hdl/gate_output_stage.sv */
`timescale 1ns/1ps

module gate_output_stage (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  anpc_pkg::gate_word_t                     leg_gate [anpc_pkg::NUM_LEGS],
    input  logic [anpc_pkg::NUM_LEGS-1:0]            leg_done,
    input  logic [anpc_pkg::NUM_LEGS-1:0]            leg_reject,
    input  logic [2*anpc_pkg::NUM_LEGS-1:0]          flag_clear,
    output logic [anpc_pkg::NUM_LEGS*anpc_pkg::GATE_W-1:0] gates,
    output logic [anpc_pkg::NUM_LEGS-1:0]            done_flags,
    output logic [anpc_pkg::NUM_LEGS-1:0]            reject_flags,
    output logic                                     irq
);
    import anpc_pkg::*;

    logic [NUM_LEGS*GATE_W-1:0] gates_nxt;
    logic [NUM_LEGS-1:0]        done_nxt;
    logic [NUM_LEGS-1:0]        reject_nxt;

    always_comb begin
        for (int i = 0; i < NUM_LEGS; i++) begin
            gates_nxt[i*GATE_W +: GATE_W] = leg_gate[i];  // Leg 0 lowest
        end
    end

    // Set wins over clear
    assign done_nxt   = leg_done | (done_flags & ~flag_clear[NUM_LEGS-1:0]);
    assign reject_nxt = leg_reject | (reject_flags & ~flag_clear[NUM_LEGS +: NUM_LEGS]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gates        <= {NUM_LEGS{GATE_N}};
            done_flags   <= '0;
            reject_flags <= '0;
            irq          <= 1'b0;
        end else begin
            gates        <= gates_nxt;
            done_flags   <= done_nxt;
            reject_flags <= reject_nxt;
            irq          <= |{done_nxt, reject_nxt};  // Tracks the flags
        end
    end

endmodule

/* hdl/leg_sequencer.sv */
`timescale 1ns/1ps

module leg_sequencer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  anpc_pkg::tdelay_t    t_short,
    input  anpc_pkg::tdelay_t    t_off_on,
    input  anpc_pkg::tdelay_t    t_on_off_v0,
    input  anpc_pkg::tdelay_t    t_off_v0_on,
    input  anpc_pkg::tdelay_t    t_off_on_i0,
    input  logic                 req,
    input  anpc_pkg::leg_state_t target,
    output anpc_pkg::gate_word_t gate_word,
    output logic                 busy,
    output logic                 done,
    output logic                 reject,
    output anpc_pkg::leg_state_t state
);
    import anpc_pkg::*;

    leg_state_t old_state;
    step_t      step;
    tdelay_t    cnt;
    tdelay_t    dt;
    tdelay_t    dt_last;
    leg_state_t tbl_new;
    leg_state_t tbl_old;
    gate_word_t tbl_word;
    dt_sel_t    dt_sel;
    logic       last_step;
    logic       legal;
    logic       step_end;

    // Idle legs look up the requested pair and busy legs the running one
    assign tbl_new = busy ? state : target;
    assign tbl_old = busy ? old_state : state;

    commutation_table u_table (
        .state     (tbl_new),
        .old_state (tbl_old),
        .step      (step),
        .gate_word (tbl_word),
        .dt_sel    (dt_sel),
        .last_step (last_step),
        .legal     (legal)
    );

    always_comb begin
        case (dt_sel)
            DT_OFF_ON:    dt = t_off_on;
            DT_ON_OFF_V0: dt = t_on_off_v0;
            DT_OFF_V0_ON: dt = t_off_v0_on;
            DT_OFF_ON_I0: dt = t_off_on_i0;
            default:      dt = t_short;
        endcase
    end

    assign dt_last   = (dt == '0) ? '0 : dt - 1'b1;  // Zero counts as one cycle
    assign step_end  = busy && (cnt == dt_last);
    assign gate_word = busy ? tbl_word : steady_word(state);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= N;
            old_state <= N;
            step      <= '0;
            cnt       <= '0;
            busy      <= 1'b0;
            done      <= 1'b0;
            reject    <= 1'b0;
        end else begin
            done   <= 1'b0;
            reject <= 1'b0;
            if (req) begin
                if (busy || !legal) begin
                    reject <= 1'b1;  // Leg keeps its state
                end else begin
                    busy      <= 1'b1;
                    old_state <= state;
                    state     <= target;
                    step      <= '0;
                    cnt       <= '0;
                end
            end
            if (step_end) begin
                cnt <= '0;
                if (last_step) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                    step <= '0;
                end else begin
                    step <= step + 1'b1;
                end
            end else if (busy) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

/* hdl/wb_leg_regs.sv */
`timescale 1ns/1ps

module wb_leg_regs (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            wb_cyc,
    input  logic                            wb_stb,
    input  logic                            wb_we,
    input  anpc_pkg::wb_addr_t              wb_adr,
    input  anpc_pkg::wb_data_t              wb_dat_w,
    output anpc_pkg::wb_data_t              wb_dat_r,
    output logic                            wb_ack,
    input  logic [anpc_pkg::NUM_LEGS-1:0]   leg_busy,
    input  anpc_pkg::leg_state_t            leg_state [anpc_pkg::NUM_LEGS],
    input  logic [anpc_pkg::NUM_LEGS-1:0]   done_flags,
    input  logic [anpc_pkg::NUM_LEGS-1:0]   reject_flags,
    input  logic                            irq,
    output anpc_pkg::tdelay_t               t_short,
    output anpc_pkg::tdelay_t               t_off_on,
    output anpc_pkg::tdelay_t               t_on_off_v0,
    output anpc_pkg::tdelay_t               t_off_v0_on,
    output anpc_pkg::tdelay_t               t_off_on_i0,
    output logic [anpc_pkg::NUM_LEGS-1:0]   req,
    output anpc_pkg::leg_state_t            target,
    output logic [2*anpc_pkg::NUM_LEGS-1:0] flag_clear
);
    import anpc_pkg::*;

    logic                access;
    logic                wr_en;
    logic [NUM_LEGS-1:0] req_nxt;
    wb_data_t            rd_data;

    assign access = wb_cyc && wb_stb && !wb_ack;  // One ack per strobe
    assign wr_en  = access && wb_we;

    always_comb begin
        for (int i = 0; i < NUM_LEGS; i++) begin
            req_nxt[i] = wr_en && (wb_adr == wb_addr_t'(ADDR_CMD0 + i));
        end
    end

    ////////////////////
    // Read mux
    ////////////////////
    always_comb begin
        rd_data = '0;
        case (wb_adr)
            ADDR_T_SHORT:     rd_data[TDELAY_W-1:0] = t_short;
            ADDR_T_OFF_ON:    rd_data[TDELAY_W-1:0] = t_off_on;
            ADDR_T_ON_OFF_V0: rd_data[TDELAY_W-1:0] = t_on_off_v0;
            ADDR_T_OFF_V0_ON: rd_data[TDELAY_W-1:0] = t_off_v0_on;
            ADDR_T_OFF_ON_I0: rd_data[TDELAY_W-1:0] = t_off_on_i0;
            ADDR_STATUS: begin
                rd_data[NUM_LEGS-1:0]  = done_flags;
                rd_data[4 +: NUM_LEGS] = reject_flags;
                rd_data[8]             = irq;
            end
            default: begin
                for (int i = 0; i < NUM_LEGS; i++) begin
                    if (wb_adr == wb_addr_t'(ADDR_CMD0 + i)) begin
                        rd_data[2:0] = leg_state[i];  // Current state
                        rd_data[4]   = leg_busy[i];
                    end
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack      <= 1'b0;
            req         <= '0;
            flag_clear  <= '0;
            t_short     <= DEF_T_SHORT;
            t_off_on    <= DEF_T_OFF_ON;
            t_on_off_v0 <= DEF_T_ON_OFF_V0;
            t_off_v0_on <= DEF_T_OFF_V0_ON;
            t_off_on_i0 <= DEF_T_OFF_ON_I0;
        end else begin
            wb_ack     <= access;
            req        <= req_nxt;  // Single cycle, with the ack
            flag_clear <= '0;
            if (wr_en) begin
                case (wb_adr)
                    ADDR_T_SHORT:     t_short     <= wb_dat_w[TDELAY_W-1:0];
                    ADDR_T_OFF_ON:    t_off_on    <= wb_dat_w[TDELAY_W-1:0];
                    ADDR_T_ON_OFF_V0: t_on_off_v0 <= wb_dat_w[TDELAY_W-1:0];
                    ADDR_T_OFF_V0_ON: t_off_v0_on <= wb_dat_w[TDELAY_W-1:0];
                    ADDR_T_OFF_ON_I0: t_off_on_i0 <= wb_dat_w[TDELAY_W-1:0];
                    ADDR_STATUS: begin
                        flag_clear <= {wb_dat_w[4 +: NUM_LEGS], wb_dat_w[NUM_LEGS-1:0]};
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            wb_dat_r <= rd_data;
        end
        if (wr_en) begin
            target <= leg_state_t'(wb_dat_w[2:0]);  // Shared by all legs
        end
    end

endmodule

/* list.f */
+incdir+include
hdl/anpc_pkg.sv
hdl/commutation_table.sv
hdl/leg_sequencer.sv
hdl/wb_leg_regs.sv
hdl/gate_output_stage.sv
hdl/anpc_bridge_top.sv
verif/tb_anpc_top.sv

/* run.sh */
#!/bin/sh
# Compile and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f list.f --top-module tb_anpc_top -o sim_anpc || exit 1
./obj_dir/sim_anpc | tee /dev/stderr | grep -q "Test passed" && echo "PASS" && exit 0 || exit 1

/* include/ref_sequence.svh */
`ifndef REF_SEQUENCE_SVH
`define REF_SEQUENCE_SVH

// Step count, four step words (step 0 first) and four dead-time indices
function automatic logic [38:0] ref_pair(input leg_state_t nw, input leg_state_t old);
    case ({old, nw})
        {Z_U2, P}:    return {3'd3, 24'b010000_110000_110001_000000,
                              DT_OFF_ON, DT_SHORT, DT_SHORT, DT_SHORT};
        {Z_U1, P}:    return {3'd4, 24'b010010_010011_010001_110001,
                              DT_OFF_ON_I0, DT_SHORT, DT_OFF_ON, DT_SHORT};
        {Z_L1, P}:    return {3'd2, 24'b100001_110001_000000_000000,
                              DT_OFF_ON, DT_SHORT, DT_SHORT, DT_SHORT};
        {Z_L2, P}:    return {3'd3, 24'b011001_010001_110001_000000,
                              DT_SHORT, DT_OFF_ON, DT_SHORT, DT_SHORT};
        {P, Z_U2}:    return {3'd3, 24'b110000_010000_010010_000000,
                              DT_SHORT, DT_OFF_ON, DT_SHORT, DT_SHORT};
        {N, Z_U2}:    return {3'd3, 24'b001010_011010_010010_000000,
                              DT_OFF_ON, DT_ON_OFF_V0, DT_ON_OFF_V0, DT_SHORT};
        {N, Z_U1}:    return {3'd2, 24'b000110_010110_000000_000000,
                              DT_OFF_ON, DT_SHORT, DT_SHORT, DT_SHORT};
        {P, Z_L1}:    return {3'd2, 24'b100001_101001_000000_000000,
                              DT_OFF_ON, DT_SHORT, DT_SHORT, DT_SHORT};
        {P, Z_L2}:    return {3'd3, 24'b010001_011001_001001_000000,
                              DT_OFF_ON, DT_ON_OFF_V0, DT_OFF_V0_ON, DT_SHORT};
        {N, Z_L2}:    return {3'd3, 24'b001100_001000_001001_000000,
                              DT_SHORT, DT_OFF_ON, DT_SHORT, DT_SHORT};
        {Z_U2, N}:    return {3'd3, 24'b011010_001010_001110_000000,
                              DT_SHORT, DT_OFF_ON, DT_SHORT, DT_SHORT};
        {Z_U1, N}:    return {3'd2, 24'b000110_001110_000000_000000,
                              DT_OFF_ON, DT_SHORT, DT_SHORT, DT_SHORT};
        {Z_L1, N}:    return {3'd4, 24'b001001_001011_001010_001110,
                              DT_OFF_ON_I0, DT_SHORT, DT_OFF_ON, DT_SHORT};
        {Z_L2, N}:    return {3'd3, 24'b001000_001100_001110_000000,
                              DT_OFF_ON, DT_SHORT, DT_SHORT, DT_SHORT};
        default:      return '0;  // Pair not in the table
    endcase
endfunction

function automatic int ref_step_count(input leg_state_t nw, input leg_state_t old);
    logic [38:0] r;
    r = ref_pair(nw, old);
    return int'(r[38:36]);
endfunction

function automatic logic [5:0] ref_step_word(input leg_state_t nw, input leg_state_t old,
                                              input int i);
    logic [38:0] r;
    r = ref_pair(nw, old);
    return r[35 - 6*i -: 6];
endfunction

function automatic int ref_step_dt(input leg_state_t nw, input leg_state_t old, input int i);
    logic [38:0] r;
    r = ref_pair(nw, old);
    return int'(r[11 - 3*i -: 3]);
endfunction

function automatic bit ref_legal(input leg_state_t nw, input leg_state_t old);
    return ref_step_count(nw, old) != 0;
endfunction

`endif

/* verif/tb_anpc_top.sv */
`timescale 1ns/1ps

module tb_anpc_top;
    import anpc_pkg::*;
    `include "ref_sequence.svh"

    localparam int N_CMDS          = 26;
    localparam int MAX_DT          = 20;
    localparam int WATCHDOG_CYCLES = N_CMDS * (4 * MAX_DT + 200) + 500;

    logic                        clk;
    logic                        rst_n;
    logic                        wb_cyc;
    logic                        wb_stb;
    logic                        wb_we;
    wb_addr_t                    wb_adr;
    wb_data_t                    wb_dat_w;
    wb_data_t                    wb_dat_r;
    logic                        wb_ack;
    logic [NUM_LEGS*GATE_W-1:0]  gates;
    logic                        irq;

    int          errors;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          test_err0;
    int          dur_checks;
    int          cycle;
    logic [31:0] lcg_state = 32'd96;
    int          dt_val [5];
    leg_state_t  leg_cur [NUM_LEGS];
    gate_word_t  exp_word [$];
    int          exp_len [$];
    int          prev_len;
    int          last_change;
    gate_word_t  last_word;

    anpc_bridge_top u_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .gates    (gates),
        .irq      (irq)
    );

    always #4 clk = ~clk;  // 8 ns period

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] got);
        errors++;
        $display("error %s expected %h got %h", name, exp_v, got);
    endtask

    ////////////////////
    // Compare process on leg 0 gates
    ////////////////////
    always @(posedge clk) begin
        gate_word_t w;
        if (!rst_n) begin
            last_word = GATE_N;
        end else if (gates[GATE_W-1:0] !== last_word) begin
            if (exp_word.size() == 0) begin
                errors++;
                $display("leg 0 gates changed from %h to %h with no transition running",
                         last_word, gates[GATE_W-1:0]);
            end else begin
                w = exp_word.pop_front();
                if (gates[GATE_W-1:0] !== w)
                    report_mismatch("gates[5:0]", 32'(w), 32'(gates[GATE_W-1:0]));
                if (prev_len != 0) begin
                    dur_checks++;
                    if (cycle - last_change != prev_len)
                        report_mismatch("step_length", prev_len, cycle - last_change);
                end
                prev_len = exp_len.pop_front();
            end
            last_word   = gates[GATE_W-1:0];
            last_change = cycle;
        end
    end

    ////////////////////
    // Bus tasks
    ////////////////////
    task automatic wb_write(input wb_addr_t a, input wb_data_t d);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= a;
        wb_dat_w <= d;
        do @(posedge clk); while (wb_ack !== 1'b1);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_read(input wb_addr_t a, output wb_data_t d);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= a;
        do @(posedge clk); while (wb_ack !== 1'b1);
        d = wb_dat_r;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    task automatic write_dt(input int idx, input int val);
        wb_write(wb_addr_t'(ADDR_T_SHORT + idx), wb_data_t'(val));
        dt_val[idx] = val;
    endtask

    task automatic randomize_dts();
        for (int i = 0; i < 5; i++) write_dt(i, int'(lcg_next() % 16) + 1);
    endtask

    // Queue the expected words and step lengths of leg 0
    task automatic arm_expect(input leg_state_t old, input leg_state_t nw);
        int n;
        int d;
        n = ref_step_count(nw, old);
        prev_len = 0;
        for (int i = 0; i < n; i++) begin
            d = dt_val[ref_step_dt(nw, old, i)];
            exp_word.push_back(ref_step_word(nw, old, i));
            exp_len.push_back((i == n - 1) ? 0 : ((d == 0) ? 1 : d));
        end
    endtask

    task automatic wait_flag(input int bit_idx);
        wb_data_t s;
        int       n;
        n = 0;
        do begin
            wb_read(ADDR_STATUS, s);
            n++;
        end while (!s[bit_idx] && n < 500);
        if (!s[bit_idx]) begin
            errors++;
            $display("status flag bit %0d never set", bit_idx);
        end
    endtask

    task automatic check_leg(input int leg, input leg_state_t st);
        wb_data_t   r;
        gate_word_t w;
        w = ref_step_word(st, leg_cur[leg], ref_step_count(st, leg_cur[leg]) - 1);
        wb_read(wb_addr_t'(ADDR_CMD0 + leg), r);
        if (r[4:0] !== {2'b00, st})
            report_mismatch("cmd_readback", 32'({2'b00, st}), 32'(r[4:0]));
        if (gates[leg*GATE_W +: GATE_W] !== w)
            report_mismatch("gates_leg", 32'(w), 32'(gates[leg*GATE_W +: GATE_W]));
        leg_cur[leg] = st;
    endtask

    // Full legal transition on leg 0 that waits for its done flag
    task automatic run_leg0(input leg_state_t nw);
        if (!ref_legal(nw, leg_cur[0])) begin
            errors++;
            $display("pair %s to %s is not a legal transition", leg_cur[0].name(), nw.name());
        end
        wb_write(ADDR_STATUS, 32'h77);
        arm_expect(leg_cur[0], nw);
        wb_write(ADDR_CMD0, wb_data_t'(nw));
        wait_flag(0);
        repeat (2) @(posedge clk);
        if (exp_word.size() != 0) begin
            errors++;
            $display("leg 0 sequence ended with %0d words missing", exp_word.size());
            exp_word.delete();
            exp_len.delete();
        end
        check_leg(0, nw);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != test_err0) begin
            tests_failed++;
            $display("%s: FAILED with %0d errors", name, errors - test_err0);
        end else begin
            $display("%s: ok", name);
        end
        test_err0 = errors;
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run is stuck", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial begin
        leg_state_t tour [18];
        int         defaults [5];
        int         dc;
        wb_data_t   r;
        tour = '{Z_U1, P, Z_L1, N, Z_U2, P, Z_L2, N, Z_L2, P, Z_U2, N, Z_U1, N, Z_L2, P,
                 Z_L1, P};
        defaults = '{4, 10, 6, 8, 12};
        clk        = 1'b0;
        errors     = 0;
        dur_checks = 0;
        cycle      = 0;
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        dt_val   = defaults;
        prev_len = 0;
        for (int i = 0; i < NUM_LEGS; i++) leg_cur[i] = N;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        test_err0 = 0;

        ///////////////////// Reset and readback
        @(posedge clk);
        if (gates !== {NUM_LEGS{GATE_N}})
            report_mismatch("gates", 32'({NUM_LEGS{GATE_N}}), 32'(gates));
        if (irq !== 1'b0) report_mismatch("irq", 0, 32'(irq));
        for (int i = 0; i < 5; i++) begin
            wb_read(wb_addr_t'(ADDR_T_SHORT + i), r);
            if (r !== wb_data_t'(defaults[i])) report_mismatch("dead_time", defaults[i], r);
        end
        randomize_dts();
        for (int i = 0; i < 5; i++) begin
            wb_read(wb_addr_t'(ADDR_T_SHORT + i), r);
            if (r !== wb_data_t'(dt_val[i])) report_mismatch("dead_time", dt_val[i], r);
        end
        end_test("test 1 reset and readback");

        ///////////////////// All legal pairs on leg 0
        foreach (tour[i]) begin
            randomize_dts();
            run_leg0(tour[i]);
        end
        end_test("test 2 every legal transition");

        ///////////////////// Step lengths, P to Z_L2
        for (int i = 0; i < 5; i++) write_dt(i, 3 + 2 * i);
        dc = dur_checks;
        run_leg0(Z_L2);
        if (dur_checks - dc != 2) begin
            errors++;
            $display("only %0d step lengths were measured instead of 2", dur_checks - dc);
        end
        end_test("test 3 step duration");

        ///////////////////// Undefined pair, then a command while busy
        wb_write(ADDR_STATUS, 32'h77);
        wb_write(ADDR_CMD0, wb_data_t'(Z_U1));
        wait_flag(4);
        wb_read(ADDR_STATUS, r);
        if (r[8] !== 1'b1) report_mismatch("status_irq", 1, 32'(r[8]));
        if (irq !== 1'b1) report_mismatch("irq", 1, 32'(irq));
        wb_read(ADDR_CMD0, r);
        if (r[4:0] !== {2'b00, Z_L2})
            report_mismatch("cmd_readback", 32'({2'b00, Z_L2}), 32'(r[4:0]));
        if (gates[GATE_W-1:0] !== GATE_Z_L2)
            report_mismatch("gates[5:0]", 32'(GATE_Z_L2), 32'(gates[GATE_W-1:0]));
        for (int i = 0; i < 5; i++) write_dt(i, MAX_DT);
        wb_write(ADDR_STATUS, 32'h77);
        arm_expect(Z_L2, N);
        wb_write(ADDR_CMD0, wb_data_t'(N));
        wb_write(ADDR_CMD0, wb_data_t'(Z_U1));  // Legal from N, but the leg is still busy
        wait_flag(4);
        if (irq !== 1'b1) report_mismatch("irq", 1, 32'(irq));
        wait_flag(0);
        repeat (2) @(posedge clk);
        check_leg(0, N);
        end_test("test 4 rejection");

        ///////////////////// Three legs in parallel, then clear
        randomize_dts();
        wb_write(ADDR_STATUS, 32'h77);
        arm_expect(N, Z_U2);
        wb_write(ADDR_CMD0, wb_data_t'(Z_U2));
        wb_write(wb_addr_t'(ADDR_CMD0 + 1), wb_data_t'(Z_U1));
        wb_write(wb_addr_t'(ADDR_CMD0 + 2), wb_data_t'(Z_L2));
        for (int i = 0; i < NUM_LEGS; i++) wait_flag(i);
        repeat (2) @(posedge clk);
        check_leg(0, Z_U2);
        check_leg(1, Z_U1);
        check_leg(2, Z_L2);
        wb_write(ADDR_STATUS, 32'h77);
        wb_read(ADDR_STATUS, r);
        if (r[8:0] !== 9'h0) report_mismatch("status", 0, 32'(r[8:0]));
        if (irq !== 1'b0) report_mismatch("irq", 0, 32'(irq));
        end_test("test 5 parallel legs and clearing");

        $display("tests run %0d, failed %0d, errors %0d, step lengths checked %0d",
                 tests_run, tests_failed, errors, dur_checks);
        if (errors == 0 && tests_failed == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
